// File: issue_top.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/issue_pkg.sv
rtl/regfile.sv
rtl/fust_table.sv
rtl/fust_age.sv
rtl/fust_fsm.sv
rtl/issue_out.sv
rtl/issue_top.sv
bench/issue_top_tb.sv

// File: Bender.yml
package:
  name: issue_top

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/isa_pkg.sv
      - rtl/issue_pkg.sv
      - rtl/regfile.sv
      - rtl/fust_table.sv
      - rtl/fust_age.sv
      - rtl/fust_fsm.sv
      - rtl/issue_out.sv
      - rtl/issue_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - bench/issue_top_tb.sv

// File: bench/issue_top_tb.sv
/* issue stage testbench */
`timescale 1ns/1ps
`default_nettype none

`include "issue_params.svh"

module issue_top_tb;

    localparam int WAIT_LIMIT = 50;

    // one table row per cycle
    // exp is the issue packet seen after the edge that samples the row
    typedef struct packed {
        issue_pkg::disp_t       disp;
        issue_pkg::wb_t         wb;
        logic                   freeze;
        logic [`NUM_SLOTS-1:0]  busy_mask;
        logic [`NUM_SLOTS-1:0]  busy_exp;
        issue_pkg::issue_t      exp;
    } step_t;

    logic                   CLK;
    logic                   nRST;
    issue_pkg::disp_t       disp;
    issue_pkg::wb_t         wb;
    logic                   freeze;
    logic [`NUM_SLOTS-1:0]  busy;
    issue_pkg::issue_t      out;

    // lfsr state, write values and shadow register file
    logic [31:0]            lfsr;
    logic [`DATA_W-1:0]     wval [4];
    logic [`DATA_W-1:0]     model [`NUM_REGS];
    step_t                  steps [$];

    issue_top i_issue_top (
        .CLK(CLK), .nRST(nRST), .disp(disp), .wb(wb), .freeze(freeze),
        .busy(busy), .out(out)
    );

    // 8 ns clock
    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // fibonacci lfsr, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one step per bit taken
    task automatic rand_word(output logic [`DATA_W-1:0] w);
        w = '0;
        for (int b = 0; b < `DATA_W; b++) begin
            w = {w[`DATA_W-2:0], lfsr[31]};
            lfsr = lfsr_next(lfsr);
        end
    endtask

    // scalar view dispatch, t3 always zero
    function automatic issue_pkg::disp_t scalar_disp(
        input isa_pkg::fu_slot_e slot, input isa_pkg::opcode_t opc,
        input isa_pkg::regbits_t rd, input isa_pkg::regbits_t rs1,
        input isa_pkg::regbits_t rs2, input isa_pkg::tag_t t1, input isa_pkg::tag_t t2
    );
        issue_pkg::disp_t d;
        d = '0;
        d.en = 1'b1;
        d.slot = slot;
        d.row.opcode = opc;
        d.row.ops.scalar.rd = rd;
        d.row.ops.scalar.rs1 = rs1;
        d.row.ops.scalar.rs2 = rs2;
        d.row.t1 = t1;
        d.row.t2 = t2;
        return d;
    endfunction

    // gemm dispatch with no pending producers
    function automatic issue_pkg::disp_t matrix_disp(
        input isa_pkg::opcode_t opc, input isa_pkg::matbits_t md,
        input isa_pkg::matbits_t ms1, input isa_pkg::matbits_t ms2,
        input isa_pkg::matbits_t ms3
    );
        issue_pkg::disp_t d;
        d = '0;
        d.en = 1'b1;
        d.slot = isa_pkg::SLOT_GEMM;
        d.row.opcode = opc;
        d.row.ops.matrix.md = md;
        d.row.ops.matrix.ms1 = ms1;
        d.row.ops.matrix.ms2 = ms2;
        d.row.ops.matrix.ms3 = ms3;
        return d;
    endfunction

    function automatic issue_pkg::wb_t wb_cmd(
        input logic en, input isa_pkg::fu_slot_e slot, input logic rw_en,
        input isa_pkg::regbits_t rw, input logic [`DATA_W-1:0] data
    );
        issue_pkg::wb_t w;
        w.en = en;
        w.slot = slot;
        w.rw_en = rw_en;
        w.rw = rw;
        w.wdata = data;
        return w;
    endfunction

    // scalar packet, matrix fields stay zero
    function automatic issue_pkg::issue_t scalar_pkt(
        input isa_pkg::fu_slot_e fu, input isa_pkg::opcode_t opc,
        input isa_pkg::regbits_t rd, input logic [`DATA_W-1:0] d1,
        input logic [`DATA_W-1:0] d2
    );
        issue_pkg::issue_t p;
        p = '0;
        p.valid = 1'b1;
        p.fu = fu;
        p.opcode = opc;
        p.rd = rd;
        p.rdat1 = d1;
        p.rdat2 = d2;
        return p;
    endfunction

    // gemm packet carries the matrix view as dispatched
    function automatic issue_pkg::issue_t gemm_pkt(input issue_pkg::disp_t d);
        issue_pkg::issue_t p;
        p = '0;
        p.valid = 1'b1;
        p.fu = isa_pkg::SLOT_GEMM;
        p.opcode = d.row.opcode;
        p.md = d.row.ops.matrix.md;
        p.ms1 = d.row.ops.matrix.ms1;
        p.ms2 = d.row.ops.matrix.ms2;
        p.ms3 = d.row.ops.matrix.ms3;
        return p;
    endfunction

    task automatic add_step(
        input issue_pkg::disp_t d, input issue_pkg::wb_t w, input logic frz,
        input issue_pkg::issue_t e, input logic [`NUM_SLOTS-1:0] bmask,
        input logic [`NUM_SLOTS-1:0] bexp
    );
        step_t s;
        s.disp = d;
        s.wb = w;
        s.freeze = frz;
        s.busy_mask = bmask;
        s.busy_exp = bexp;
        s.exp = e;
        steps.push_back(s);
        // shadow follows writes in table order, r0 stays zero
        if (w.rw_en && (w.rw != '0)) begin
            model[w.rw] = w.wdata;
        end
    endtask

    task automatic add_idle(input issue_pkg::issue_t e);
        add_step('0, '0, 1'b0, e, '0, '0);
    endtask

    task automatic build_table();
        issue_pkg::disp_t  gemm_d;
        issue_pkg::issue_t gemm_p;
        gemm_d = matrix_disp(4'h5, 4'ha, 4'h3, 4'hc, 4'h5);
        gemm_p = gemm_pkt(gemm_d);
        // two register writes, then an alu op with no tags
        add_step('0, wb_cmd(1'b0, isa_pkg::SLOT_ALU, 1'b1, 5'd3, wval[0]), 1'b0, '0, '0, '0);
        add_step('0, wb_cmd(1'b0, isa_pkg::SLOT_ALU, 1'b1, 5'd4, wval[1]), 1'b0, '0, '0, '0);
        add_step(scalar_disp(isa_pkg::SLOT_ALU, 4'h1, 5'd5, 5'd3, 5'd4, 3'd0, 3'd0),
                 '0, 1'b0, '0, '0, '0);
        add_idle('0);
        add_idle(scalar_pkt(isa_pkg::SLOT_ALU, 4'h1, 5'd5, model[3], model[4]));
        // ldst waits on the alu through t1
        add_step(scalar_disp(isa_pkg::SLOT_LDST, 4'h2, 5'd6, 5'd5, 5'd3, 3'd1, 3'd0),
                 '0, 1'b0, '0, '0, '0);
        add_step('0, '0, 1'b0, '0, 5'b00011, 5'b00011);
        add_idle('0);
        // alu finishes and writes r5, its busy bit drops
        add_step('0, wb_cmd(1'b1, isa_pkg::SLOT_ALU, 1'b1, 5'd5, wval[2]), 1'b0, '0,
                 5'b00011, 5'b00010);
        add_idle('0);
        add_idle(scalar_pkt(isa_pkg::SLOT_LDST, 4'h2, 5'd6, model[5], model[3]));
        // mldst goes in first, br second, both wait on ldst
        add_step(scalar_disp(isa_pkg::SLOT_MLDST, 4'h3, 5'd7, 5'd4, 5'd3, 3'd2, 3'd0),
                 '0, 1'b0, '0, '0, '0);
        add_step(scalar_disp(isa_pkg::SLOT_BR, 4'h4, 5'd0, 5'd3, 5'd5, 3'd0, 3'd2),
                 '0, 1'b0, '0, '0, '0);
        add_step('0, wb_cmd(1'b1, isa_pkg::SLOT_LDST, 1'b1, 5'd7, wval[3]), 1'b0, '0, '0, '0);
        add_idle('0);
        // older mldst wins over the lower index
        add_idle(scalar_pkt(isa_pkg::SLOT_MLDST, 4'h3, 5'd7, model[4], model[3]));
        add_idle(scalar_pkt(isa_pkg::SLOT_BR, 4'h4, 5'd0, model[3], model[5]));
        // gemm dispatched alongside the br writeback
        add_step(gemm_d, wb_cmd(1'b1, isa_pkg::SLOT_BR, 1'b0, 5'd0, '0), 1'b0, '0, '0, '0);
        add_idle('0);
        add_idle(gemm_p);
        // freeze holds the gemm packet while a new alu op gets ready
        add_step(scalar_disp(isa_pkg::SLOT_ALU, 4'h6, 5'd8, 5'd7, 5'd4, 3'd0, 3'd0),
                 '0, 1'b1, gemm_p, '0, '0);
        for (int k = 0; k < 3; k++) begin
            add_step('0, '0, 1'b1, gemm_p, '0, '0);
        end
        add_idle(scalar_pkt(isa_pkg::SLOT_ALU, 4'h6, 5'd8, model[7], model[4]));
        // drain every slot still in execute
        add_step('0, wb_cmd(1'b1, isa_pkg::SLOT_MLDST, 1'b0, 5'd0, '0), 1'b0, '0, '0, '0);
        add_step('0, wb_cmd(1'b1, isa_pkg::SLOT_GEMM, 1'b0, 5'd0, '0), 1'b0, '0, '0, '0);
        add_step('0, wb_cmd(1'b1, isa_pkg::SLOT_ALU, 1'b0, 5'd0, '0), 1'b0, '0, '0, '0);
    endtask

    task automatic abort_run();
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_step(input int i);
        assert (out === steps[i].exp) else begin
            $display("error out step %0d got %h exp %h", i, out, steps[i].exp);
            abort_run();
        end
        assert ((busy & steps[i].busy_mask) === steps[i].busy_exp) else begin
            $display("error busy step %0d got %h exp %h mask %h", i, busy,
                     steps[i].busy_exp, steps[i].busy_mask);
            abort_run();
        end
    endtask

    // poll at negedge until every slot is free
    task automatic wait_busy_clear();
        int n;
        n = 0;
        while (busy !== '0) begin
            @(negedge CLK);
            n++;
            if (n > WAIT_LIMIT) begin
                $display("timed out waiting for all slots to become free");
                abort_run();
            end
        end
    endtask

    initial begin
        nRST = 1'b0;
        disp = '0;
        wb = '0;
        freeze = 1'b0;
        lfsr = 32'h6fc4a42d;
        for (int r = 0; r < `NUM_REGS; r++) begin
            model[r] = '0;
        end
        for (int k = 0; k < 4; k++) begin
            rand_word(wval[k]);
        end
        build_table();
        repeat (10) @(posedge CLK);
        nRST <= 1'b1;
        // quiet after reset
        for (int c = 0; c < 4; c++) begin
            @(negedge CLK);
            assert (busy === '0) else begin
                $display("error busy got %h exp %h", busy, 5'h0);
                abort_run();
            end
            assert (out.valid === 1'b0) else begin
                $display("error out.valid got %h exp %h", out.valid, 1'b0);
                abort_run();
            end
        end
        wait_busy_clear();
        // row i driven at the edge, its result checked one cycle later
        for (int i = 0; i < steps.size(); i++) begin
            @(posedge CLK);
            disp <= steps[i].disp;
            wb <= steps[i].wb;
            freeze <= steps[i].freeze;
            @(negedge CLK);
            if (i > 0) begin
                check_step(i - 1);
            end
        end
        @(posedge CLK);
        disp <= '0;
        wb <= '0;
        freeze <= 1'b0;
        @(negedge CLK);
        check_step(steps.size() - 1);
        wait_busy_clear();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: rtl/issue_top.sv
/* issue stage top */
`timescale 1ns/1ps
`default_nettype none

`include "issue_params.svh"

module issue_top (
    input  wire logic             CLK,
    input  wire logic             nRST,
    input  wire issue_pkg::disp_t disp,
    input  wire issue_pkg::wb_t   wb,
    input  wire logic             freeze,
    output logic [`NUM_SLOTS-1:0] busy,
    output issue_pkg::issue_t     out
);

    issue_pkg::fust_row_t [`NUM_SLOTS-1:0]  rows;
    issue_pkg::fust_state_e [`NUM_SLOTS-1:0] state;
    logic [`NUM_SLOTS-1:0][`AGE_W-1:0]       ages;
    logic [`NUM_SLOTS-1:0]                   issue_sel;
    logic                                    issue_go;
    isa_pkg::regbits_t                       rsel1;
    isa_pkg::regbits_t                       rsel2;
    logic [`DATA_W-1:0]                      rdat1;
    logic [`DATA_W-1:0]                      rdat2;

    // scalar writeback shares the completion strobe bundle
    regfile i_regfile (
        .CLK(CLK), .nRST(nRST),
        .wen(wb.rw_en), .wsel(wb.rw), .wdata(wb.wdata),
        .rsel1(rsel1), .rsel2(rsel2), .rdat1(rdat1), .rdat2(rdat2)
    );

    fust_table i_fust_table (
        .CLK(CLK), .nRST(nRST), .disp(disp), .wb(wb), .rows(rows)
    );

    fust_age i_fust_age (
        .CLK(CLK), .nRST(nRST), .disp(disp), .state(state),
        .issue_sel(issue_sel), .ages(ages)
    );

    fust_fsm i_fust_fsm (
        .CLK(CLK), .nRST(nRST), .disp(disp), .wb(wb), .freeze(freeze),
        .rows(rows), .ages(ages), .state(state), .busy(busy),
        .issue_sel(issue_sel), .issue_go(issue_go)
    );

    issue_out i_issue_out (
        .CLK(CLK), .nRST(nRST), .freeze(freeze), .issue_go(issue_go),
        .issue_sel(issue_sel), .rows(rows), .rsel1(rsel1), .rsel2(rsel2),
        .rdat1(rdat1), .rdat2(rdat2), .out(out)
    );

endmodule

`default_nettype wire

// File: rtl/issue_out.sv
/* operand read and issue register */
`timescale 1ns/1ps
`default_nettype none

`include "issue_params.svh"

module issue_out (
    input  wire logic                                   CLK,
    input  wire logic                                   nRST,
    input  wire logic                                   freeze,
    input  wire logic                                   issue_go,
    input  wire logic [`NUM_SLOTS-1:0]                  issue_sel,
    input  wire issue_pkg::fust_row_t [`NUM_SLOTS-1:0] rows,
    output isa_pkg::regbits_t                           rsel1,
    output isa_pkg::regbits_t                           rsel2,
    input  wire logic [`DATA_W-1:0]                     rdat1,
    input  wire logic [`DATA_W-1:0]                     rdat2,
    output issue_pkg::issue_t                           out
);

    issue_pkg::fust_row_t sel_row;
    isa_pkg::fu_slot_e    sel_slot;
    issue_pkg::issue_t    n_out;
    logic                 is_gemm;

    // one-hot mux of the chosen row
    always_comb begin : row_pick
        sel_row  = '0;
        sel_slot = isa_pkg::SLOT_ALU;
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            if (issue_sel[i]) begin
                sel_row  = rows[i];
                sel_slot = isa_pkg::fu_slot_e'(3'(i));
            end
        end
    end

    assign is_gemm = (sel_slot == isa_pkg::SLOT_GEMM);

    // gemm has no scalar sources, park the ports on r0
    assign rsel1 = is_gemm ? '0 : sel_row.ops.scalar.rs1;
    assign rsel2 = is_gemm ? '0 : sel_row.ops.scalar.rs2;

    always_comb begin : packet_build
        n_out = '0;
        if (issue_go) begin
            n_out.valid  = 1'b1;
            n_out.fu     = sel_slot;
            n_out.opcode = sel_row.opcode;
            if (is_gemm) begin
                // matrix view of the operand word
                n_out.md  = sel_row.ops.matrix.md;
                n_out.ms1 = sel_row.ops.matrix.ms1;
                n_out.ms2 = sel_row.ops.matrix.ms2;
                n_out.ms3 = sel_row.ops.matrix.ms3;
            end else begin
                n_out.rd    = sel_row.ops.scalar.rd;
                n_out.rdat1 = rdat1;
                n_out.rdat2 = rdat2;
            end
        end
    end

    // freeze holds the whole packet, valid included
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            out <= '0;
        end else if (!freeze) begin
            out <= n_out;
        end
    end

endmodule

`default_nettype wire

// File: rtl/fust_fsm.sv
/* slot scoreboard and issue select */
`timescale 1ns/1ps
`default_nettype none

`include "issue_params.svh"

module fust_fsm (
    input  wire logic                                    CLK,
    input  wire logic                                    nRST,
    input  wire issue_pkg::disp_t                        disp,
    input  wire issue_pkg::wb_t                          wb,
    input  wire logic                                    freeze,
    input  wire issue_pkg::fust_row_t [`NUM_SLOTS-1:0]  rows,
    input  wire logic [`NUM_SLOTS-1:0][`AGE_W-1:0]       ages,
    output issue_pkg::fust_state_e [`NUM_SLOTS-1:0]      state,
    output logic [`NUM_SLOTS-1:0]                        busy,
    output logic [`NUM_SLOTS-1:0]                        issue_sel,
    output logic                                         issue_go
);

    issue_pkg::fust_state_e [`NUM_SLOTS-1:0] next_state;
    logic [`NUM_SLOTS-1:0]                   disp_hit;
    logic [`NUM_SLOTS-1:0]                   wb_hit;
    logic [`NUM_SLOTS-1:0]                   tags_clear;
    logic [`AGE_W-1:0]                       best_age;
    logic                                    found;

    always_comb begin : slot_decode
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            disp_hit[i]   = disp.en && (disp.slot == 3'(i));
            wb_hit[i]     = wb.en && (wb.slot == 3'(i));
            // all producers done
            tags_clear[i] = (rows[i].t1 == '0) && (rows[i].t2 == '0) &&
                            (rows[i].t3 == '0);
            // a finishing slot is free for dispatch on the same edge
            busy[i] = (state[i] != issue_pkg::FUST_EMPTY) &&
                      !((state[i] == issue_pkg::FUST_EX) && wb_hit[i]);
        end
    end

    // oldest ready slot wins
    // strict compare keeps the lowest index on a tie
    always_comb begin : oldest_select
        issue_sel = '0;
        best_age  = '0;
        found     = 1'b0;
        if (!freeze) begin
            for (int i = 0; i < `NUM_SLOTS; i++) begin
                if ((state[i] == issue_pkg::FUST_RDY) && (!found || (ages[i] > best_age))) begin
                    issue_sel    = '0;
                    issue_sel[i] = 1'b1;
                    best_age     = ages[i];
                    found        = 1'b1;
                end
            end
        end
    end

    assign issue_go = |issue_sel;

    always_comb begin : state_next
        next_state = state;
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            case (state[i])
                issue_pkg::FUST_EMPTY: begin
                    if (disp_hit[i]) next_state[i] = issue_pkg::FUST_WAIT;
                end
                issue_pkg::FUST_WAIT: begin
                    if (tags_clear[i]) next_state[i] = issue_pkg::FUST_RDY;
                end
                issue_pkg::FUST_RDY: begin
                    if (issue_sel[i]) next_state[i] = issue_pkg::FUST_EX;
                end
                issue_pkg::FUST_EX: begin
                    // refill straight from writeback
                    if (wb_hit[i]) begin
                        next_state[i] = disp_hit[i] ? issue_pkg::FUST_WAIT
                                                    : issue_pkg::FUST_EMPTY;
                    end
                end
                default: next_state[i] = issue_pkg::FUST_EMPTY;
            endcase
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < `NUM_SLOTS; i++) begin
                state[i] <= issue_pkg::FUST_EMPTY;
            end
        end else begin
            state <= next_state;
        end
    end

    // dispatch honours the busy level
    a_disp_free: assert property (
        @(posedge CLK) disable iff (!nRST)
        disp.en |-> !busy[disp.slot]
    ) else $error("dispatch into busy slot %0d", disp.slot);

    a_sel_onehot: assert property (
        @(posedge CLK) disable iff (!nRST)
        $onehot0(issue_sel)
    ) else $error("issue_sel not one-hot %b", issue_sel);

endmodule

`default_nettype wire

// File: rtl/fust_age.sv
/* slot age counters */
`timescale 1ns/1ps
`default_nettype none

`include "issue_params.svh"

module fust_age (
    input  wire logic                                     CLK,
    input  wire logic                                     nRST,
    input  wire issue_pkg::disp_t                         disp,
    input  wire issue_pkg::fust_state_e [`NUM_SLOTS-1:0] state,
    input  wire logic [`NUM_SLOTS-1:0]                    issue_sel,
    output logic [`NUM_SLOTS-1:0][`AGE_W-1:0]             ages
);

    localparam logic [`AGE_W-1:0] AGE_ONE = 1;
    localparam logic [`AGE_W-1:0] AGE_MAX = '1;

    logic [`NUM_SLOTS-1:0][`AGE_W-1:0] n_ages;
    logic [`NUM_SLOTS-1:0]             active;

    always_comb begin : age_next
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            // waiting or ready slots keep aging
            active[i] = (state[i] == issue_pkg::FUST_WAIT) ||
                        (state[i] == issue_pkg::FUST_RDY);
            n_ages[i] = ages[i];
            if (disp.en && (disp.slot == 3'(i))) begin
                // youngest entry
                n_ages[i] = AGE_ONE;
            end else if (issue_sel[i]) begin
                // leaves for execute
                n_ages[i] = '0;
            end else if (disp.en && active[i] && (ages[i] != AGE_MAX)) begin
                n_ages[i] = ages[i] + AGE_ONE;
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            ages <= '0;
        end else begin
            ages <= n_ages;
        end
    end

    // a slot waiting for issue always carries an age
    for (genvar g = 0; g < `NUM_SLOTS; g++) begin : g_age_chk
        a_age_live: assert property (
            @(posedge CLK) disable iff (!nRST)
            ((state[g] == issue_pkg::FUST_WAIT) || (state[g] == issue_pkg::FUST_RDY))
                |-> (ages[g] != '0)
        ) else $error("slot %0d pending with zero age", g);
    end

endmodule

`default_nettype wire

// File: rtl/fust_table.sv
/* functional unit status table */
`timescale 1ns/1ps
`default_nettype none

`include "issue_params.svh"

module fust_table (
    input  wire logic                      CLK,
    input  wire logic                      nRST,
    input  wire issue_pkg::disp_t          disp,
    input  wire issue_pkg::wb_t            wb,
    output issue_pkg::fust_row_t [`NUM_SLOTS-1:0] rows
);

    issue_pkg::fust_row_t [`NUM_SLOTS-1:0] n_rows;
    isa_pkg::tag_t                         fin_tag;

    // zero any source tag that names the finishing slot
    function automatic issue_pkg::fust_row_t clear_tag(
        input issue_pkg::fust_row_t row,
        input isa_pkg::tag_t        tag
    );
        issue_pkg::fust_row_t r;
        r = row;
        if (r.t1 == tag) begin
            r.t1 = '0;
        end
        if (r.t2 == tag) begin
            r.t2 = '0;
        end
        if (r.t3 == tag) begin
            r.t3 = '0;
        end
        return r;
    endfunction

    // tag of the slot finishing this cycle
    // slot n is tag n+1 so zero stays free
    assign fin_tag = isa_pkg::tag_t'(wb.slot) + isa_pkg::tag_t'(1);

    always_comb begin : row_update
        n_rows = rows;
        for (int i = 0; i < `NUM_SLOTS; i++) begin
            // resident rows see the broadcast
            if (wb.en) begin
                n_rows[i] = clear_tag(rows[i], fin_tag);
            end
            // new row replaces the slot
            if (disp.en && (disp.slot == 3'(i))) begin
                n_rows[i] = disp.row;
                // producer finishing on this same edge
                if (wb.en) begin
                    n_rows[i] = clear_tag(disp.row, fin_tag);
                end
            end
        end
    end

    // tags are scoreboard state so they start clean
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rows <= '0;
        end else begin
            rows <= n_rows;
        end
    end

endmodule

`default_nettype wire

// File: rtl/regfile.sv
/* scalar register file */
`timescale 1ns/1ps
`default_nettype none

`include "issue_params.svh"

module regfile (
    input  wire logic               CLK,
    input  wire logic               nRST,
    input  wire logic               wen,
    input  wire isa_pkg::regbits_t  wsel,
    input  wire logic [`DATA_W-1:0] wdata,
    input  wire isa_pkg::regbits_t  rsel1,
    input  wire isa_pkg::regbits_t  rsel2,
    output logic [`DATA_W-1:0]      rdat1,
    output logic [`DATA_W-1:0]      rdat2
);

    logic [`NUM_REGS-1:0][`DATA_W-1:0] regs;

    // write on the edge
    // writes to r0 are dropped
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            regs <= '0;
        end else if (wen && (wsel != '0)) begin
            regs[wsel] <= wdata;
        end
    end

    // combinational reads
    // r0 forced to zero
    always_comb begin
        rdat1 = (rsel1 == '0) ? '0 : regs[rsel1];
        rdat2 = (rsel2 == '0) ? '0 : regs[rsel2];
    end

    // writeback must never name an unknown register
    a_wsel_known: assert property (
        @(posedge CLK) disable iff (!nRST)
        wen |-> !$isunknown(wsel)
    ) else $error("regfile write with unknown wsel %h", wsel);

endmodule

`default_nettype wire

// File: rtl/issue_pkg.sv
/* issue stage state types */
`default_nettype none

`include "issue_params.svh"

package issue_pkg;

    // per-slot scoreboard state
    typedef enum logic [1:0] {
        FUST_EMPTY = 2'd0,
        FUST_WAIT  = 2'd1,
        FUST_RDY   = 2'd2,
        FUST_EX    = 2'd3
    } fust_state_e;

    // one status table row
    // t3 only meaningful for gemm, zero elsewhere
    typedef struct packed {
        isa_pkg::opcode_t  opcode;
        isa_pkg::operands_u ops;
        isa_pkg::tag_t     t1;
        isa_pkg::tag_t     t2;
        isa_pkg::tag_t     t3;
    } fust_row_t;

    // dispatch write into one slot
    typedef struct packed {
        logic              en;
        isa_pkg::fu_slot_e slot;
        fust_row_t         row;
    } disp_t;

    // writeback completion plus register write
    typedef struct packed {
        logic              en;
        isa_pkg::fu_slot_e slot;
        logic              rw_en;
        isa_pkg::regbits_t rw;
        logic [`DATA_W-1:0] wdata;
    } wb_t;

    // packet handed to execute
    typedef struct packed {
        logic               valid;
        isa_pkg::fu_slot_e  fu;
        isa_pkg::opcode_t   opcode;
        isa_pkg::regbits_t  rd;
        logic [`DATA_W-1:0] rdat1;
        logic [`DATA_W-1:0] rdat2;
        isa_pkg::matbits_t  md;
        isa_pkg::matbits_t  ms1;
        isa_pkg::matbits_t  ms2;
        isa_pkg::matbits_t  ms3;
    } issue_t;

endpackage

`default_nettype wire

// File: rtl/isa_pkg.sv
/* instruction field types */
`default_nettype none

package isa_pkg;

    // scalar register number
    typedef logic [4:0] regbits_t;

    // matrix register number
    typedef logic [3:0] matbits_t;

    // opcode is opaque here and goes straight to execute
    typedef logic [3:0] opcode_t;

    // functional unit slot names
    // value doubles as the slot index
    typedef enum logic [2:0] {
        SLOT_ALU   = 3'd0,
        SLOT_LDST  = 3'd1,
        SLOT_BR    = 3'd2,
        SLOT_MLDST = 3'd3,
        SLOT_GEMM  = 3'd4
    } fu_slot_e;

    // producer tag
    // 0 means no pending producer, n waits on slot n-1
    typedef logic [2:0] tag_t;

    // scalar view of the operand field
    typedef struct packed {
        logic     rsvd;
        regbits_t rd;
        regbits_t rs1;
        regbits_t rs2;
    } scalar_ops_t;

    // matrix view, used by gemm only
    typedef struct packed {
        matbits_t md;
        matbits_t ms1;
        matbits_t ms2;
        matbits_t ms3;
    } matrix_ops_t;

    // same 16 bits, decoded by slot
    // matrix ldst still uses the scalar view for its address base
    typedef union packed {
        scalar_ops_t scalar;
        matrix_ops_t matrix;
    } operands_u;

endpackage

`default_nettype wire

// File: rtl/issue_params.svh
/* issue stage sizing */
`ifndef ISSUE_PARAMS_SVH
`define ISSUE_PARAMS_SVH

// one status table slot per functional unit
// alu, ldst, branch, matrix ldst, gemm
`define NUM_SLOTS 5

// age counter width
// saturates at 7, enough to order five slots
`define AGE_W 3

// scalar datapath width
`define DATA_W 32

// scalar register count
// register 0 reads as zero
`define NUM_REGS 32

`endif
